/* ddr3_cfg_pkg.sv */
`default_nettype none

package ddr3_cfg_pkg;

  // Device geometry, one 32-bit word per column
  localparam int DDR_ROW_BITS = 13;
  localparam int DDR_BANK_BITS = 3;
  localparam int DDR_COL_BITS = 8;
  localparam int WORD_ADDR_BITS = DDR_ROW_BITS + DDR_BANK_BITS + DDR_COL_BITS;
  localparam int DATA_WIDTH = 32;

  // Timing, in controller clock cycles
  localparam int T_INIT = 20;
  localparam int T_RCD = 3;
  localparam int T_WR = 3;
  localparam int T_RP = 3;

  // Row in the upper bits, column in the lower bits
  typedef struct packed {
    logic [DDR_ROW_BITS-1:0]  row;
    logic [DDR_BANK_BITS-1:0] bank;
    logic [DDR_COL_BITS-1:0]  col;
  } ddr_rbc_t;

  typedef union packed {
    logic [WORD_ADDR_BITS-1:0] flat;
    ddr_rbc_t                  rbc;
  } ddr_addr_u;

  typedef struct packed {
    logic                     cs_n;
    logic                     ras_n;
    logic                     cas_n;
    logic                     we_n;
    logic [DDR_BANK_BITS-1:0] bank;
    logic [DDR_ROW_BITS-1:0]  addr;
  } dfi_cmd_t;

  // {cs_n, ras_n, cas_n, we_n}
  localparam logic [3:0] DFI_NOP = 4'b0111;
  localparam logic [3:0] DFI_MRS = 4'b0000;
  localparam logic [3:0] DFI_ACT = 4'b0011;
  localparam logic [3:0] DFI_RD = 4'b0101;
  localparam logic [3:0] DFI_WR = 4'b0100;
  localparam logic [3:0] DFI_PRE = 4'b0010;

  function automatic dfi_cmd_t dfi_cmd(input logic [3:0] strobes,
                                       input logic [DDR_BANK_BITS-1:0] bank,
                                       input logic [DDR_ROW_BITS-1:0] addr);
    dfi_cmd_t c;
    {c.cs_n, c.ras_n, c.cas_n, c.we_n} = strobes;
    c.bank = bank;
    c.addr = addr;
    return c;
  endfunction

endpackage

`default_nettype wire

/* memreq_pkg.sv */
`default_nettype none

package memreq_pkg;

  import ddr3_cfg_pkg::*;

  // First byte of every command frame
  typedef enum logic [7:0] {
    OP_WRITE = 8'h01,
    OP_READ  = 8'h02
  } mem_op_e;

  // Opcode, three address bytes, then four data bytes for a write
  localparam int FRAME_LEN_RD = 4;
  localparam int FRAME_LEN_WR = 8;

  typedef struct packed {
    logic                  write;
    ddr_addr_u             addr;
    logic [DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  // One word returned by a read
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
  } rd_word_t;

endpackage

`default_nettype wire

/* memreq_parser.sv */
`timescale 1ns/10ps
`default_nettype none

module memreq_parser
  import ddr3_cfg_pkg::*;
  import memreq_pkg::*;
(
  input  wire            clock,
  input  wire            rst_n_i,
  input  wire            s_tvalid_i,
  output logic           s_tready_o,
  input  wire            s_tlast_i,
  input  wire      [7:0] s_tdata_i,
  input  wire            busy_i,
  output logic           req_stb_o,
  output mem_req_t       req_o
);

  localparam int SR_W = WORD_ADDR_BITS + DATA_WIDTH;

  logic [3:0]      byte_cnt;
  logic [7:0]      op_q;
  logic [SR_W-1:0] sr_q;
  logic [SR_W-1:0] sr_next;
  logic            req_vld;
  logic            beat;
  logic            frame_ok;

  assign beat = s_tvalid_i && s_tready_o;
  assign sr_next = {sr_q[SR_W-9:0], s_tdata_i};

  // Hold off the stream while a request waits or the sequencer works
  assign s_tready_o = !req_vld && !busy_i;
  assign req_stb_o = req_vld && !busy_i;

  // Only valid on the beat carrying tlast
  always_comb begin
    frame_ok = 1'b0;
    if (op_q == OP_WRITE && byte_cnt == 4'(FRAME_LEN_WR - 1)) begin
      frame_ok = 1'b1;
    end
    if (op_q == OP_READ && byte_cnt == 4'(FRAME_LEN_RD - 1)) begin
      frame_ok = 1'b1;
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      byte_cnt <= '0;
      req_vld  <= 1'b0;
    end else begin
      if (req_stb_o) begin
        req_vld <= 1'b0;
      end
      if (beat) begin
        if (s_tlast_i) begin
          byte_cnt <= '0;
          req_vld  <= frame_ok;
        end else if (byte_cnt != 4'hf) begin
          // Saturate so that long frames never match a valid length
          byte_cnt <= byte_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (beat) begin
      if (byte_cnt == 4'd0) begin
        op_q <= s_tdata_i;
      end else begin
        sr_q <= sr_next;
      end
    end
    if (beat && s_tlast_i && frame_ok) begin
      req_o.write <= (op_q == OP_WRITE);
      req_o.wdata <= sr_next[DATA_WIDTH-1:0];
      if (op_q == OP_WRITE) begin
        req_o.addr.flat <= sr_next[SR_W-1 -: WORD_ADDR_BITS];
      end else begin
        req_o.addr.flat <= sr_next[WORD_ADDR_BITS-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* ddr3_cmd_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module ddr3_cmd_seq
  import ddr3_cfg_pkg::*;
  import memreq_pkg::*;
#(
  parameter int DDR_CL  = 6,
  parameter int DDR_CWL = 6
) (
  input  wire                   clock,
  input  wire                   rst_n_i,
  input  wire                   req_stb_i,
  input  wire mem_req_t         req_i,
  output logic                  busy_o,
  input  wire                   ser_idle_i,
  output logic                  configured_o,
  output logic                  dfi_cke_o,
  output dfi_cmd_t              dfi_cmd_o,
  output logic                  dfi_wren_o,
  output logic [DATA_WIDTH-1:0] dfi_wdata_o,
  output logic                  dfi_rden_o,
  input  wire                   dfi_rvld_i,
  input  wire  [DATA_WIDTH-1:0] dfi_rdata_i,
  output logic                  rd_stb_o,
  output rd_word_t              rd_word_o
);

  // CAS latency field of MR0 sits in A[6:4]
  localparam logic [DDR_ROW_BITS-1:0] MRS_ADDR = DDR_ROW_BITS'((DDR_CL - 4) << 4);

  typedef enum logic [3:0] {
    ST_INIT,
    ST_MRS,
    ST_IDLE,
    ST_ACT,
    ST_CDLY,
    ST_WLAT,
    ST_WREC,
    ST_RWAIT,
    ST_PRE
  } seq_state_e;

  seq_state_e              state_q;
  logic [7:0]              cnt_q;
  mem_req_t                req_q;
  logic [DDR_ROW_BITS-1:0] col_addr;

  assign col_addr = {{(DDR_ROW_BITS - DDR_COL_BITS){1'b0}}, req_q.addr.rbc.col};

  // Read requests also wait for the serializer to drain
  assign busy_o = (state_q != ST_IDLE) || !ser_idle_i;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_INIT;
      cnt_q        <= 8'(T_INIT - 1);
      dfi_cke_o    <= 1'b0;
      configured_o <= 1'b0;
      dfi_cmd_o    <= dfi_cmd(DFI_NOP, '0, '0);
      dfi_wren_o   <= 1'b0;
      dfi_rden_o   <= 1'b0;
      rd_stb_o     <= 1'b0;
    end else begin
      dfi_cmd_o  <= dfi_cmd(DFI_NOP, '0, '0);
      dfi_wren_o <= 1'b0;
      dfi_rden_o <= 1'b0;
      rd_stb_o   <= 1'b0;
      case (state_q)
        ST_INIT: begin
          if (cnt_q != 8'd0) begin
            cnt_q <= cnt_q - 8'd1;
          end else if (!dfi_cke_o) begin
            dfi_cke_o <= 1'b1;
          end else begin
            dfi_cmd_o <= dfi_cmd(DFI_MRS, '0, MRS_ADDR);
            state_q   <= ST_MRS;
          end
        end
        ST_MRS: begin
          configured_o <= 1'b1;
          state_q      <= ST_IDLE;
        end
        ST_IDLE: begin
          if (req_stb_i) begin
            dfi_cmd_o <= dfi_cmd(DFI_ACT, req_i.addr.rbc.bank, req_i.addr.rbc.row);
            state_q   <= ST_ACT;
          end
        end
        ST_ACT: begin
          cnt_q   <= 8'(T_RCD - 2);
          state_q <= ST_CDLY;
        end
        ST_CDLY: begin
          if (cnt_q != 8'd0) begin
            cnt_q <= cnt_q - 8'd1;
          end else if (req_q.write) begin
            dfi_cmd_o <= dfi_cmd(DFI_WR, req_q.addr.rbc.bank, col_addr);
            cnt_q     <= 8'(DDR_CWL - 1);
            state_q   <= ST_WLAT;
          end else begin
            dfi_cmd_o  <= dfi_cmd(DFI_RD, req_q.addr.rbc.bank, col_addr);
            dfi_rden_o <= 1'b1;
            state_q    <= ST_RWAIT;
          end
        end
        ST_WLAT: begin
          if (cnt_q != 8'd0) begin
            cnt_q <= cnt_q - 8'd1;
          end else begin
            dfi_wren_o <= 1'b1;
            cnt_q      <= 8'(T_WR - 1);
            state_q    <= ST_WREC;
          end
        end
        ST_WREC: begin
          if (cnt_q != 8'd0) begin
            cnt_q <= cnt_q - 8'd1;
          end else begin
            dfi_cmd_o <= dfi_cmd(DFI_PRE, req_q.addr.rbc.bank, '0);
            cnt_q     <= 8'(T_RP);
            state_q   <= ST_PRE;
          end
        end
        ST_RWAIT: begin
          // Read latency is whatever the PHY returns
          if (dfi_rvld_i) begin
            rd_stb_o  <= 1'b1;
            dfi_cmd_o <= dfi_cmd(DFI_PRE, req_q.addr.rbc.bank, '0);
            cnt_q     <= 8'(T_RP);
            state_q   <= ST_PRE;
          end
        end
        ST_PRE: begin
          if (cnt_q != 8'd0) begin
            cnt_q <= cnt_q - 8'd1;
          end else begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == ST_IDLE && req_stb_i) begin
      req_q <= req_i;
    end
    if (state_q == ST_WLAT && cnt_q == 8'd0) begin
      dfi_wdata_o <= req_q.wdata;
    end
    if (state_q == ST_RWAIT && dfi_rvld_i) begin
      rd_word_o.data <= dfi_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* rdata_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module rdata_serializer
  import ddr3_cfg_pkg::*;
  import memreq_pkg::*;
(
  input  wire            clock,
  input  wire            rst_n_i,
  input  wire            rd_stb_i,
  input  wire rd_word_t  rd_word_i,
  output logic           m_tvalid_o,
  input  wire            m_tready_i,
  output logic           m_tlast_o,
  output logic     [7:0] m_tdata_o,
  output logic           idle_o
);

  localparam int NBYTES = DATA_WIDTH / 8;

  logic [DATA_WIDTH-1:0] sr_q;
  logic [1:0]            byte_cnt;
  logic                  vld_q;

  // MSB goes out first
  assign m_tdata_o = sr_q[DATA_WIDTH-1 -: 8];
  assign m_tlast_o = (byte_cnt == 2'(NBYTES - 1));
  assign m_tvalid_o = vld_q;
  assign idle_o = !vld_q;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_q    <= 1'b0;
      byte_cnt <= '0;
    end else if (rd_stb_i) begin
      vld_q    <= 1'b1;
      byte_cnt <= '0;
    end else if (vld_q && m_tready_i) begin
      if (m_tlast_o) begin
        vld_q <= 1'b0;
      end else begin
        byte_cnt <= byte_cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_stb_i) begin
      sr_q <= rd_word_i.data;
    end else if (vld_q && m_tready_i) begin
      sr_q <= {sr_q[DATA_WIDTH-9:0], 8'h00};
    end
  end

endmodule

`default_nettype wire

/* ddr3_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ddr3_top
  import ddr3_cfg_pkg::*;
  import memreq_pkg::*;
#(
  // CAS and CAS-write latency, 5 to 8
  parameter int DDR_CL  = 6,
  parameter int DDR_CWL = 6
) (
  input  wire                   clock,
  input  wire                   rst_n_i,
  output logic                  configured_o,

  // Command frames in
  input  wire                   s_tvalid_i,
  output logic                  s_tready_o,
  input  wire                   s_tlast_i,
  input  wire  [7:0]            s_tdata_i,

  // Read data out
  output logic                  m_tvalid_o,
  input  wire                   m_tready_i,
  output logic                  m_tlast_o,
  output logic [7:0]            m_tdata_o,

  // DFI command and data port
  output logic                  dfi_cke_o,
  output dfi_cmd_t              dfi_cmd_o,
  output logic                  dfi_wren_o,
  output logic [DATA_WIDTH-1:0] dfi_wdata_o,
  output logic                  dfi_rden_o,
  input  wire                   dfi_rvld_i,
  input  wire  [DATA_WIDTH-1:0] dfi_rdata_i
);

  logic     req_stb;
  mem_req_t req;
  logic     busy;
  logic     rd_stb;
  rd_word_t rd_word;
  logic     ser_idle;

  memreq_parser u_parser (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .s_tvalid_i(s_tvalid_i),
    .s_tready_o(s_tready_o),
    .s_tlast_i (s_tlast_i),
    .s_tdata_i (s_tdata_i),
    .busy_i    (busy),
    .req_stb_o (req_stb),
    .req_o     (req)
  );

  ddr3_cmd_seq #(
    .DDR_CL (DDR_CL),
    .DDR_CWL(DDR_CWL)
  ) u_cmd_seq (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .req_stb_i   (req_stb),
    .req_i       (req),
    .busy_o      (busy),
    .ser_idle_i  (ser_idle),
    .configured_o(configured_o),
    .dfi_cke_o   (dfi_cke_o),
    .dfi_cmd_o   (dfi_cmd_o),
    .dfi_wren_o  (dfi_wren_o),
    .dfi_wdata_o (dfi_wdata_o),
    .dfi_rden_o  (dfi_rden_o),
    .dfi_rvld_i  (dfi_rvld_i),
    .dfi_rdata_i (dfi_rdata_i),
    .rd_stb_o    (rd_stb),
    .rd_word_o   (rd_word)
  );

  rdata_serializer u_serializer (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .rd_stb_i  (rd_stb),
    .rd_word_i (rd_word),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o),
    .idle_o    (ser_idle)
  );

endmodule

`default_nettype wire

/* tb_ddr3_dfi_model.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ddr3_dfi_model
  import ddr3_cfg_pkg::*;
#(
  parameter int DDR_CL = 6
) (
  input  wire                   clock,
  input  wire                   rst_n_i,
  input  wire dfi_cmd_t         dfi_cmd_i,
  input  wire                   dfi_wren_i,
  input  wire  [DATA_WIDTH-1:0] dfi_wdata_i,
  output logic                  dfi_rvld_o,
  output logic [DATA_WIDTH-1:0] dfi_rdata_o
);

  // Word store indexed by the low column address bits
  logic [DATA_WIDTH-1:0]   mem [256];
  logic [7:0]              wcol_q;
  logic [15:0]             rd_pipe;
  logic [3:0]              strobes;

  assign strobes = {dfi_cmd_i.cs_n, dfi_cmd_i.ras_n, dfi_cmd_i.cas_n, dfi_cmd_i.we_n};
  assign dfi_rvld_o = rd_pipe[DDR_CL-1];

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h3c, 8'h96};
    end
  end

  // Read data returns DDR_CL cycles after RD
  always @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_pipe <= '0;
    end else begin
      rd_pipe <= {rd_pipe[14:0], (strobes == DFI_RD)};
    end
  end

  always @(posedge clock) begin
    if (strobes == DFI_WR) begin
      wcol_q <= dfi_cmd_i.addr[7:0];
    end
    if (strobes == DFI_RD) begin
      dfi_rdata_o <= mem[dfi_cmd_i.addr[7:0]];
    end
    if (dfi_wren_i) begin
      mem[wcol_q] <= dfi_wdata_i;
    end
  end

endmodule

`default_nettype wire

/* tb_ddr3_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ddr3_top
  import ddr3_cfg_pkg::*;
  import memreq_pkg::*;
;

  localparam int DDR_CL = 6;
  localparam int DDR_CWL = 6;
  localparam int N_WR = 24;
  localparam int N_RD = 24;
  localparam int N_FRAMES = N_WR + N_RD + 6;
  // Worst case per frame with input gaps and output stalls
  localparam int FRAME_CYC = 150;
  localparam logic [31:0] EV_WREN = 32'h10;
  localparam logic [31:0] EV_RVLD = 32'h11;

  logic                  clock;
  logic                  rst_n_i;
  logic                  configured_o;
  logic                  s_tvalid_i;
  logic                  s_tready_o;
  logic                  s_tlast_i;
  logic [7:0]            s_tdata_i;
  logic                  m_tvalid_o;
  logic                  m_tready_i;
  logic                  m_tlast_o;
  logic [7:0]            m_tdata_o;
  logic                  dfi_cke_o;
  dfi_cmd_t              dfi_cmd_o;
  logic                  dfi_wren_o;
  logic [DATA_WIDTH-1:0] dfi_wdata_o;
  logic                  dfi_rden_o;
  logic                  dfi_rvld_i;
  logic [DATA_WIDTH-1:0] dfi_rdata_i;
  logic [3:0]            strobes;

  logic [31:0] lfsr = 32'd78509;
  int          cyc = 0;
  int          last_acc = 0;
  int          cke_cyc = -1;
  int          cfg_cyc = -1;
  int          rel_cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          act_overlap = 0;
  logic        ready_early = 1'b0;

  // DFI activity seen since the last clear
  logic [31:0] ev_kind[$];
  logic [31:0] ev_cyc[$];
  logic [31:0] ev_addr[$];
  logic [31:0] ev_bank[$];
  logic [31:0] ev_data[$];
  logic [7:0]  out_q[$];
  logic        out_last_q[$];
  logic [31:0] ref_mem [logic [23:0]];
  logic [23:0] wr_addr [N_WR];

  assign strobes = {dfi_cmd_o.cs_n, dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n};

  ddr3_top #(
    .DDR_CL (DDR_CL),
    .DDR_CWL(DDR_CWL)
  ) i_ddr3_top (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .configured_o(configured_o),
    .s_tvalid_i  (s_tvalid_i),
    .s_tready_o  (s_tready_o),
    .s_tlast_i   (s_tlast_i),
    .s_tdata_i   (s_tdata_i),
    .m_tvalid_o  (m_tvalid_o),
    .m_tready_i  (m_tready_i),
    .m_tlast_o   (m_tlast_o),
    .m_tdata_o   (m_tdata_o),
    .dfi_cke_o   (dfi_cke_o),
    .dfi_cmd_o   (dfi_cmd_o),
    .dfi_wren_o  (dfi_wren_o),
    .dfi_wdata_o (dfi_wdata_o),
    .dfi_rden_o  (dfi_rden_o),
    .dfi_rvld_i  (dfi_rvld_i),
    .dfi_rdata_i (dfi_rdata_i)
  );

  tb_ddr3_dfi_model #(
    .DDR_CL(DDR_CL)
  ) u_model (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .dfi_cmd_i  (dfi_cmd_o),
    .dfi_wren_i (dfi_wren_o),
    .dfi_wdata_i(dfi_wdata_o),
    .dfi_rvld_o (dfi_rvld_i),
    .dfi_rdata_o(dfi_rdata_i)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic log_event(input logic [31:0] kind, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] d);
    ev_kind.push_back(kind);
    ev_cyc.push_back(32'(cyc));
    ev_addr.push_back(a);
    ev_bank.push_back(b);
    ev_data.push_back(d);
  endtask

  function automatic int find_ev(input logic [31:0] kind);
    foreach (ev_kind[i]) begin
      if (ev_kind[i] == kind) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic clear_events();
    ev_kind.delete();
    ev_cyc.delete();
    ev_addr.delete();
    ev_bank.delete();
    ev_data.delete();
    out_q.delete();
    out_last_q.delete();
  endtask

  // Monitor samples values launched by the previous edge
  always @(posedge clock) begin
    cyc = cyc + 1;
    if (rst_n_i) begin
      if (s_tvalid_i && s_tready_o && s_tlast_i) last_acc = cyc;
      if (dfi_cke_o && cke_cyc < 0) cke_cyc = cyc;
      if (configured_o && cfg_cyc < 0) cfg_cyc = cyc;
      if (s_tready_o && !configured_o) ready_early = 1'b1;
      if (strobes != DFI_NOP) begin
        log_event(32'(strobes), 32'(dfi_cmd_o.addr), 32'(dfi_cmd_o.bank), 32'(dfi_rden_o));
      end
      if (strobes == DFI_ACT && m_tvalid_o) act_overlap++;
      if (dfi_wren_o) log_event(EV_WREN, 0, 0, dfi_wdata_o);
      if (dfi_rvld_i) log_event(EV_RVLD, 0, 0, dfi_rdata_i);
      if (m_tvalid_o && m_tready_i) begin
        out_q.push_back(m_tdata_o);
        out_last_q.push_back(m_tlast_o);
      end
    end
  end

  // Random output stalls, ready high three times in four
  initial begin
    m_tready_i = 1'b0;
    @(posedge rst_n_i);
    forever begin
      @(negedge clock);
      m_tready_i = (rand_bits(2) != 0);
    end
  end

  task automatic send_byte(input logic [7:0] b, input logic last);
    logic hs;
    if (rand_bits(2) == 0) begin
      s_tvalid_i = 1'b0;
      repeat (int'(rand_bits(2)) + 1) @(negedge clock);
    end
    s_tvalid_i = 1'b1;
    s_tdata_i = b;
    s_tlast_i = last;
    hs = 1'b0;
    // Ready only depends on registers, so it holds until the next rising edge
    while (!hs) begin
      hs = s_tready_o;
      @(negedge clock);
    end
  endtask

  task automatic send_frame(input logic [7:0] op, input logic [23:0] addr,
                            input logic [31:0] data, input int n);
    logic [7:0] b [8];
    b = '{op, addr[23:16], addr[15:8], addr[7:0],
          data[31:24], data[23:16], data[15:8], data[7:0]};
    for (int i = 0; i < n; i++) begin
      send_byte(b[i], i == n - 1);
    end
    s_tvalid_i = 1'b0;
    s_tlast_i = 1'b0;
  endtask

  task automatic wait_ev(input logic [31:0] kind);
    while (find_ev(kind) < 0) @(negedge clock);
  endtask

  task automatic wait_ready();
    while (!s_tready_o) @(negedge clock);
  endtask

  task automatic write_word(input logic [23:0] addr, input logic [31:0] data);
    ddr_addr_u a;
    int        ia;
    int        iw;
    int        id;
    int        ip;
    a.flat = addr;
    clear_events();
    send_frame(8'h01, addr, data, 8);
    wait_ev(32'(DFI_PRE));
    wait_ready();
    ia = find_ev(32'(DFI_ACT));
    iw = find_ev(32'(DFI_WR));
    id = find_ev(EV_WREN);
    ip = find_ev(32'(DFI_PRE));
    check("act_cycle", ev_cyc[ia], 32'(last_acc + 2));
    check("act_row", ev_addr[ia], 32'(a.rbc.row));
    check("act_bank", ev_bank[ia], 32'(a.rbc.bank));
    check("wr_cycle", ev_cyc[iw], ev_cyc[ia] + 32'(T_RCD));
    check("wr_col", ev_addr[iw], 32'(a.rbc.col));
    check("wr_bank", ev_bank[iw], 32'(a.rbc.bank));
    check("dfi_wren_cycle", ev_cyc[id], ev_cyc[iw] + 32'(DDR_CWL));
    check("dfi_wdata", ev_data[id], data);
    check("pre_cycle", ev_cyc[ip], ev_cyc[id] + 32'(T_WR));
    check("dfi_events", 32'(ev_kind.size()), 32'd4);
    ref_mem[addr] = data;
  endtask

  task automatic read_word(input logic [23:0] addr);
    ddr_addr_u   a;
    logic [31:0] exp;
    int          ia;
    int          ir;
    int          iv;
    int          ip;
    a.flat = addr;
    exp = ref_mem[addr];
    clear_events();
    send_frame(8'h02, addr, 32'h0, 4);
    wait_ev(32'(DFI_PRE));
    // The stream reopens only once all four bytes have left
    wait_ready();
    ia = find_ev(32'(DFI_ACT));
    ir = find_ev(32'(DFI_RD));
    iv = find_ev(EV_RVLD);
    ip = find_ev(32'(DFI_PRE));
    check("act_cycle", ev_cyc[ia], 32'(last_acc + 2));
    check("act_row", ev_addr[ia], 32'(a.rbc.row));
    check("rd_cycle", ev_cyc[ir], ev_cyc[ia] + 32'(T_RCD));
    check("rd_col", ev_addr[ir], 32'(a.rbc.col));
    check("rd_bank", ev_bank[ir], 32'(a.rbc.bank));
    check("dfi_rden_o", ev_data[ir], 32'd1);
    check("pre_cycle", ev_cyc[ip], ev_cyc[iv] + 32'd1);
    check("m_bytes", 32'(out_q.size()), 32'd4);
    for (int i = 0; i < 4; i++) begin
      check("m_tdata_o", 32'(out_q[i]), 32'(exp[31 - 8 * i -: 8]));
      check("m_tlast_o", 32'(out_last_q[i]), 32'(i == 3));
    end
  endtask

  task automatic reject_frame(input logic [7:0] op, input int n);
    clear_events();
    send_frame(op, 24'(rand_bits(24)), rand_bits(32), n);
    wait_ready();
    repeat (T_RCD + DDR_CL + 8) @(negedge clock);
    check("dfi_events", 32'(ev_kind.size()), 32'd0);
    check("m_bytes", 32'(out_q.size()), 32'd0);
  endtask

  task automatic end_test(input string name, input int err_start);
    $display("Test %-12s %s", name, (errors == err_start) ? "passed" : "failed");
  endtask

  initial begin
    int          e0;
    int          im;
    int          idx;
    logic [7:0]  op;
    rst_n_i = 1'b0;
    s_tvalid_i = 1'b0;
    s_tlast_i = 1'b0;
    s_tdata_i = 8'h00;

    // Reset and initialisation
    e0 = errors;
    @(negedge clock);
    check("s_tready_o", 32'(s_tready_o), 32'd0);
    check("m_tvalid_o", 32'(m_tvalid_o), 32'd0);
    check("dfi_wren_o", 32'(dfi_wren_o), 32'd0);
    check("dfi_rden_o", 32'(dfi_rden_o), 32'd0);
    check("dfi_cke_o", 32'(dfi_cke_o), 32'd0);
    check("configured_o", 32'(configured_o), 32'd0);
    check("dfi_cmd_o", 32'(strobes), 32'(DFI_NOP));
    repeat (2) @(posedge clock);
    @(negedge clock);
    rst_n_i = 1'b1;
    rel_cyc = cyc;
    while (cfg_cyc < 0) @(negedge clock);
    im = find_ev(32'(DFI_MRS));
    check("dfi_cke_cycle", 32'(cke_cyc), 32'(rel_cyc + T_INIT + 1));
    check("mrs_cycle", ev_cyc[im], 32'(cke_cyc + 1));
    check("mrs_cl", 32'(ev_addr[im][6:4]), 32'(DDR_CL - 4));
    check("dfi_events", 32'(ev_kind.size()), 32'd1);
    check("configured_cycle", 32'(cfg_cyc), ev_cyc[im] + 32'd1);
    check("early_ready", 32'(ready_early), 32'd0);
    end_test("reset_init", e0);

    // Columns kept distinct since the model aliases rows and banks
    e0 = errors;
    for (int i = 0; i < N_WR; i++) begin
      wr_addr[i] = {13'(rand_bits(13)), 3'(rand_bits(3)), 8'(i * 11)};
      write_word(wr_addr[i], rand_bits(32));
    end
    end_test("write_timing", e0);

    e0 = errors;
    for (int i = 0; i < N_RD; i++) begin
      idx = int'(rand_bits(8)) % N_WR;
      read_word(wr_addr[idx]);
    end
    check("act_overlap", 32'(act_overlap), 32'd0);
    end_test("read_back", e0);

    e0 = errors;
    op = 8'(rand_bits(8));
    if (op == 8'h01 || op == 8'h02) op = 8'h7f;
    reject_frame(op, 4);
    reject_frame(8'h01, 5);
    reject_frame(8'h02, 6);
    reject_frame(8'h01, 3);
    write_word(24'h1a2bff, 32'hc0ffee11);
    read_word(24'h1a2bff);
    end_test("bad_frames", e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #((N_FRAMES * FRAME_CYC + T_INIT + 200) * 100);
    $display("Timeout: the run did not finish in the expected time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
ddr3_cfg_pkg.sv
memreq_pkg.sv
memreq_parser.sv
ddr3_cmd_seq.sv
rdata_serializer.sv
ddr3_top.sv
tb_ddr3_dfi_model.sv
tb_ddr3_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_ddr3_top -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
  exit 0
fi
echo "Simulation reported failure"
exit 1
